// ==== include/bp_macros.svh ====
/* Branch predictor sizing
   Table geometry, stored field widths and the fetch start address */

`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// Tag bits kept per row, pc [15:6]
`define BP_TAG_SIZE 10

// Stored target bits, pc [13:2]
`define BP_TARGET_SIZE 12

`define BP_ROWS 16 // Rows in both tables

// First fetch address once reset is released
`define BP_RESET_PC 32'h0000_1000

`endif

// ==== hw/bp_pkg.sv ====
/* Branch predictor types
   Address, table field and fetch state types shared by the predictor blocks */

`include "bp_macros.svh"

package bp_pkg;

	typedef logic [31:0] pc_t; // Any instruction address

	// Row select taken from pc [5:2]
	typedef logic [$clog2(`BP_ROWS)-1:0] btb_index_t;

	typedef logic [`BP_TAG_SIZE-1:0] btb_tag_t; // pc [15:6]
	typedef logic [`BP_TARGET_SIZE-1:0] btb_target_t; // Target pc [13:2]

	// 2-bit saturating counter, upper bit is the taken guess
	typedef logic [1:0] dir_ctr_t;

	// Fetch sequencing
	typedef enum logic [1:0] {
		FETCH_IDLE, // Held in reset
		FETCH_RUN, // Normal fetch
		FETCH_RECOVER // One bubble after a redirect
	} fetch_state_t;

endpackage

// ==== hw/btb.sv ====
/* Branch target buffer
   Direct-mapped tag and target store with a write bypass into the fetch lookup */

`timescale 1ns/1ps
`include "bp_macros.svh"

module btb (
	input  logic         clock,
	input  logic         reset,
	input  bp_pkg::pc_t  lookup_pc, // Current fetch pc
	input  logic         wr_en, // Taken branch resolved in execute
	input  bp_pkg::pc_t  wr_pc, // Pc of the resolved branch
	input  bp_pkg::pc_t  wr_target, // Its computed target
	output logic         hit,
	output bp_pkg::pc_t  btb_target
);
	import bp_pkg::*;

	// Field positions within a pc
	localparam int IDX_LSB = 2;
	localparam int IDX_MSB = IDX_LSB + $clog2(`BP_ROWS) - 1;
	localparam int TAG_LSB = IDX_MSB + 1;
	localparam int TAG_MSB = TAG_LSB + `BP_TAG_SIZE - 1;
	localparam int TGT_LSB = 2;
	localparam int TGT_MSB = TGT_LSB + `BP_TARGET_SIZE - 1;

	logic [`BP_ROWS-1:0] valid;
	btb_tag_t            tag_mem [`BP_ROWS];
	btb_target_t         target_mem [`BP_ROWS];

	btb_index_t  lookup_idx;
	btb_tag_t    lookup_tag;
	btb_index_t  wr_idx;
	btb_tag_t    wr_tag;
	btb_target_t wr_tgt;
	logic        bypass;

	// Row contents as seen by the lookup
	logic        row_valid;
	btb_tag_t    row_tag;
	btb_target_t row_target;

	assign lookup_idx = lookup_pc[IDX_MSB:IDX_LSB];
	assign lookup_tag = lookup_pc[TAG_MSB:TAG_LSB];
	assign wr_idx     = wr_pc[IDX_MSB:IDX_LSB];
	assign wr_tag     = wr_pc[TAG_MSB:TAG_LSB];
	assign wr_tgt     = wr_target[TGT_MSB:TGT_LSB];

	// Same-row write this cycle wins over the stored row
	assign bypass = wr_en && (wr_idx == lookup_idx);

	always_comb begin
		row_valid  = valid[lookup_idx];
		row_tag    = tag_mem[lookup_idx];
		row_target = target_mem[lookup_idx];
		if (bypass) begin
			row_valid  = 1'b1;
			row_tag    = wr_tag;
			row_target = wr_tgt;
		end
	end

	assign hit = row_valid && (row_tag == lookup_tag);

	// Upper region and byte offset come from the fetching pc
	assign btb_target = {lookup_pc[31:TGT_MSB+1], row_target, lookup_pc[TGT_LSB-1:0]};

	// Only taken resolutions allocate or overwrite a row
	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
			for (int i = 0; i < `BP_ROWS; i++) begin
				tag_mem[i]    <= '0;
				target_mem[i] <= '0;
			end
		end else if (wr_en) begin
			valid[wr_idx]      <= 1'b1;
			tag_mem[wr_idx]    <= wr_tag; // Replaces any older branch in the row
			target_mem[wr_idx] <= wr_tgt;
		end
	end

endmodule

// ==== hw/direction_counters.sv ====
/* Direction counter table
   One 2-bit saturating counter per row, stepped by resolved branches */

`timescale 1ns/1ps
`include "bp_macros.svh"

module direction_counters (
	input  logic        clock,
	input  logic        reset,
	input  bp_pkg::pc_t lookup_pc, // Current fetch pc
	input  logic        upd_en, // Any resolved branch
	input  bp_pkg::pc_t upd_pc,
	input  logic        upd_taken, // Resolved direction
	output logic        predict_taken
);
	import bp_pkg::*;

	localparam int IDX_LSB = 2;
	localparam int IDX_MSB = IDX_LSB + $clog2(`BP_ROWS) - 1;
	localparam dir_ctr_t CTR_INIT = 2'b01; // Weakly not taken

	dir_ctr_t   ctr [`BP_ROWS];
	btb_index_t lookup_idx;
	btb_index_t upd_idx;
	dir_ctr_t   upd_next; // Stepped value of the updated row
	dir_ctr_t   lookup_ctr;

	// Saturating step toward the resolved direction
	function automatic dir_ctr_t ctr_step(input dir_ctr_t cur, input logic taken);
		dir_ctr_t stepped;
		stepped = cur;
		if (taken && cur != 2'b11)
			stepped = cur + 2'd1;
		else if (!taken && cur != 2'b00)
			stepped = cur - 2'd1;
		return stepped;
	endfunction

	assign lookup_idx = lookup_pc[IDX_MSB:IDX_LSB];
	assign upd_idx    = upd_pc[IDX_MSB:IDX_LSB];
	assign upd_next   = ctr_step(ctr[upd_idx], upd_taken);

	// Lookup sees this cycle's update on the same row
	assign lookup_ctr = (upd_en && upd_idx == lookup_idx) ? upd_next : ctr[lookup_idx];
	assign predict_taken = lookup_ctr[1]; // 10 and 11 mean taken

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `BP_ROWS; i++)
				ctr[i] <= CTR_INIT;
		end else if (upd_en) begin
			ctr[upd_idx] <= upd_next;
		end
	end

endmodule

// ==== hw/fetch_fsm.sv ====
/* Fetch sequencer
   Owns the fetch pc and picks sequential, predicted or redirected next address */

`timescale 1ns/1ps
`include "bp_macros.svh"

module fetch_fsm (
	input  logic        clock,
	input  logic        reset,
	input  logic        stall, // Hold fetch
	input  logic        if_branch, // Instruction at fetch_pc is a branch
	input  logic        hit, // Target buffer match
	input  logic        predict_taken, // Counter says taken
	input  bp_pkg::pc_t btb_target,
	input  logic        ex_redirect, // Wrong path detected in execute
	input  bp_pkg::pc_t ex_next_pc,
	output bp_pkg::pc_t fetch_pc,
	output logic        fetch_valid,
	output logic        pred_taken
);
	import bp_pkg::*;

	fetch_state_t state;
	fetch_state_t next_state;
	pc_t          pc;
	pc_t          next_pc;
	pc_t          seq_pc;

	assign seq_pc = pc + 32'd4;

	// Taken guess needs a branch, a matching row and a taken counter
	assign pred_taken = (state == FETCH_RUN) && !stall && if_branch && hit && predict_taken;

	always_comb begin
		next_state = state;
		next_pc    = pc;
		if (ex_redirect) begin
			// Execute overrides everything, stall included
			next_pc    = ex_next_pc;
			next_state = FETCH_RECOVER;
		end else begin
			case (state)
				FETCH_IDLE: begin
					next_pc    = `BP_RESET_PC; // Start address
					next_state = FETCH_RUN;
				end
				FETCH_RUN: begin
					if (!stall)
						next_pc = pred_taken ? btb_target : seq_pc;
				end
				FETCH_RECOVER: begin
					// Single bubble then resume at the redirect pc
					next_state = FETCH_RUN;
				end
				default: begin
					next_state = FETCH_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= FETCH_IDLE;
			pc    <= `BP_RESET_PC; // Keeps the pc aligned while idle
		end else begin
			state <= next_state;
			pc    <= next_pc;
		end
	end

	assign fetch_pc    = pc;
	assign fetch_valid = (state == FETCH_RUN); // Low while idle and in the bubble

endmodule

// ==== hw/branch_predictor_top.sv ====
/* Branch prediction subsystem
   Fetch sequencer with target buffer and direction counters */

`timescale 1ns/1ps

module branch_predictor_top (
	input  logic        clock,
	input  logic        reset,
	input  logic        stall,
	input  logic        if_branch,
	input  logic        ex_resolve, // Branch resolved this cycle
	input  bp_pkg::pc_t ex_pc,
	input  logic        ex_taken,
	input  bp_pkg::pc_t ex_target,
	input  logic        ex_redirect,
	input  bp_pkg::pc_t ex_next_pc,
	output bp_pkg::pc_t fetch_pc,
	output logic        fetch_valid,
	output logic        pred_taken
);
	import bp_pkg::*;

	logic btb_hit;
	pc_t  btb_target;
	logic dir_taken;
	logic btb_wr_en;

	// Only taken branches get a target buffer row
	assign btb_wr_en = ex_resolve && ex_taken;

	fetch_fsm u_fetch_fsm (
		.clock         (clock),
		.reset         (reset),
		.stall         (stall),
		.if_branch     (if_branch),
		.hit           (btb_hit),
		.predict_taken (dir_taken),
		.btb_target    (btb_target),
		.ex_redirect   (ex_redirect),
		.ex_next_pc    (ex_next_pc),
		.fetch_pc      (fetch_pc),
		.fetch_valid   (fetch_valid),
		.pred_taken    (pred_taken)
	);

	// Both tables look up the current fetch pc
	btb u_btb (
		.clock      (clock),
		.reset      (reset),
		.lookup_pc  (fetch_pc),
		.wr_en      (btb_wr_en),
		.wr_pc      (ex_pc),
		.wr_target  (ex_target),
		.hit        (btb_hit),
		.btb_target (btb_target)
	);

	direction_counters u_direction_counters (
		.clock         (clock),
		.reset         (reset),
		.lookup_pc     (fetch_pc),
		.upd_en        (ex_resolve), // Every resolution trains the counter
		.upd_pc        (ex_pc),
		.upd_taken     (ex_taken),
		.predict_taken (dir_taken)
	);

endmodule

// ==== tests/branch_predictor_props.sv ====
/* Fetch protocol checks
   Reset idle, pc alignment and stall hold, bound to the predictor top level */

`timescale 1ns/1ps

module branch_predictor_props (
	input logic        clock,
	input logic        reset,
	input logic        stall,
	input logic        ex_redirect,
	input bp_pkg::pc_t fetch_pc,
	input logic        fetch_valid
);
	import bp_pkg::*;

	int fail_count = 0; // Failed assertions so far

	// Idle through reset and the start cycle that follows it
	a_reset_idle: assert property (@(posedge clock) reset |=> !fetch_valid)
		else begin
			fail_count++;
			$error("fetch_valid high during reset or in the cycle after it");
		end

	a_pc_aligned: assert property (@(posedge clock) disable iff (reset) fetch_pc[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("fetch_pc is not word aligned");
		end

	// Stall only holds a running fetch, the bubble always ends
	a_stall_hold: assert property (@(posedge clock) disable iff (reset)
		(stall && !ex_redirect && fetch_valid) |=> ($stable(fetch_pc) && $stable(fetch_valid)))
		else begin
			fail_count++;
			$error("fetch_pc or fetch_valid moved while stalled");
		end

endmodule

// ==== tests/branch_predictor_tb.sv ====
/* Branch predictor testbench
   Directed and LFSR stimulus against a table and fetch model, checked by assertions */

`timescale 1ns/1ps
`include "bp_macros.svh"

module branch_predictor_tb;
	import bp_pkg::*;

	localparam pc_t BR_P      = 32'h0000_1040; // Row 0 with tag 041
	localparam pc_t BR_ALIAS  = 32'h0000_1080; // Row 0 with tag 042
	localparam pc_t TGT_P     = 32'h0001_2468; // Upper bits outside the branch region
	localparam pc_t BR_S      = 32'h0000_2000;
	localparam pc_t BR_U      = 32'h0000_2030; // Row 12 untouched until the bypass check
	localparam pc_t BR_W      = 32'h0000_2100;
	localparam pc_t RAND_BASE = 32'h0000_1400; // Random rows 0..7 live here
	localparam int  RESET_CYCLES    = 8;
	localparam int  DIRECTED_CYCLES = 50;
	localparam int  RANDOM_CYCLES   = 70;
	localparam int  TIMEOUT_CYCLES  = 2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES);

	logic clock = 1'b0;
	logic reset, stall, if_branch, ex_resolve, ex_taken, ex_redirect;
	pc_t  ex_pc, ex_target, ex_next_pc;
	pc_t  fetch_pc;
	logic fetch_valid, pred_taken;

	// Model of both tables and the fetch sequencer
	logic         m_valid [`BP_ROWS];
	btb_tag_t     m_tag [`BP_ROWS];
	btb_target_t  m_tgt [`BP_ROWS];
	dir_ctr_t     m_ctr [`BP_ROWS];
	fetch_state_t m_state;
	pc_t          m_pc;
	btb_index_t   look_idx, res_idx;
	logic         row_valid, exp_hit, exp_pred;
	btb_tag_t     row_tag;
	btb_target_t  row_tgt;
	dir_ctr_t     row_ctr;
	pc_t          exp_target;

	logic [15:0] lfsr = 16'd51;
	logic [7:0]  r_row, r_taken, r_dest, r_branch;
	int          errors = 0;
	int          cycles = 0;

	branch_predictor_top DUT (.*);

	bind branch_predictor_top branch_predictor_props u_props (.*);

	always #10 clock = ~clock;

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int n, output logic [7:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr  = lfsr_next(lfsr); // One step per bit
			value = {value[6:0], lfsr[0]};
		end
	endtask

	// Saturating step that sticks at 00 and 11
	function automatic dir_ctr_t counter_after(input dir_ctr_t c, input logic taken);
		if (taken)
			return (c == 2'b11) ? c : c + 2'd1;
		return (c == 2'b00) ? c : c - 2'd1;
	endfunction

	assign look_idx = m_pc[5:2];
	assign res_idx  = ex_pc[5:2];

	// Lookup at the model pc with this cycle's resolution folded in
	always_comb begin
		row_valid = m_valid[look_idx];
		row_tag   = m_tag[look_idx];
		row_tgt   = m_tgt[look_idx];
		row_ctr   = m_ctr[look_idx];
		if (ex_resolve && res_idx == look_idx) begin
			row_ctr = counter_after(m_ctr[look_idx], ex_taken);
			if (ex_taken) begin
				row_valid = 1'b1;
				row_tag   = ex_pc[15:6];
				row_tgt   = ex_target[13:2];
			end
		end
		exp_hit    = row_valid && (row_tag == m_pc[15:6]);
		exp_pred   = (m_state == FETCH_RUN) && !stall && if_branch && exp_hit && row_ctr[1];
		exp_target = {m_pc[31:14], row_tgt, m_pc[1:0]}; // Stays in the fetching region
	end

	always @(posedge clock) begin
		if (reset) begin
			m_state <= FETCH_IDLE;
			m_pc    <= `BP_RESET_PC;
			for (int i = 0; i < `BP_ROWS; i++) begin
				m_valid[i] <= 1'b0;
				m_tag[i]   <= '0;
				m_tgt[i]   <= '0;
				m_ctr[i]   <= 2'b01; // Weakly not taken
			end
		end else begin
			if (ex_resolve) begin
				m_ctr[res_idx] <= counter_after(m_ctr[res_idx], ex_taken);
				if (ex_taken) begin // Only taken branches enter the buffer
					m_valid[res_idx] <= 1'b1;
					m_tag[res_idx]   <= ex_pc[15:6];
					m_tgt[res_idx]   <= ex_target[13:2];
				end
			end
			if (ex_redirect) begin
				m_pc    <= ex_next_pc;
				m_state <= FETCH_RECOVER;
			end else if (m_state == FETCH_IDLE) begin
				m_pc    <= `BP_RESET_PC;
				m_state <= FETCH_RUN;
			end else if (m_state == FETCH_RECOVER) begin
				m_state <= FETCH_RUN;
			end else if (!stall) begin
				m_pc <= exp_pred ? exp_target : m_pc + 32'd4;
			end
		end
	end

	a_fetch_pc: assert property (@(posedge clock) disable iff (reset) fetch_pc == m_pc)
		else begin
			errors++;
			$display("error @ %0d ns: fetch_pc %h, expected %h", $time,
				$sampled(fetch_pc), $sampled(m_pc));
		end

	a_fetch_valid: assert property (@(posedge clock) disable iff (reset)
		fetch_valid == (m_state == FETCH_RUN))
		else begin
			errors++;
			$display("error @ %0d ns: fetch_valid %b at pc %h", $time,
				$sampled(fetch_valid), $sampled(m_pc));
		end

	a_pred_taken: assert property (@(posedge clock) disable iff (reset) pred_taken == exp_pred)
		else begin
			errors++;
			$display("error @ %0d ns: pred_taken %b, expected %b at pc %h", $time,
				$sampled(pred_taken), $sampled(exp_pred), $sampled(m_pc));
		end

	task automatic tick();
		@(posedge clock);
		#2;
	endtask

	task automatic resolve(input pc_t pc, input logic taken, input pc_t target);
		ex_resolve = 1'b1;
		ex_pc      = pc;
		ex_taken   = taken;
		ex_target  = target;
		tick();
		ex_resolve = 1'b0;
	endtask

	// Redirect to pc and sit out the bubble before one branch fetch
	task automatic fetch_branch(input pc_t pc);
		ex_redirect = 1'b1;
		ex_next_pc  = pc;
		tick();
		ex_redirect = 1'b0;
		tick();
		if_branch = 1'b1;
		tick();
		if_branch = 1'b0;
		repeat (2) tick();
	endtask

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		reset       = 1'b1;
		stall       = 1'b0;
		if_branch   = 1'b0;
		ex_resolve  = 1'b0;
		ex_taken    = 1'b0;
		ex_redirect = 1'b0;
		ex_pc       = '0;
		ex_target   = '0;
		ex_next_pc  = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		#2;
		reset = 1'b0;
		repeat (10) tick(); // Straight-line fetch from the reset pc
		resolve(BR_P, 1'b1, TGT_P); // Counter 01 to 10
		fetch_branch(BR_P);
		repeat (3) resolve(BR_P, 1'b0, TGT_P); // Down to 00 and held there
		fetch_branch(BR_P); // Entry kept but fetch falls through
		repeat (2) resolve(BR_P, 1'b1, TGT_P);
		fetch_branch(BR_ALIAS); // Same row with another tag

		// Redirect wins over stall
		stall       = 1'b1;
		ex_redirect = 1'b1;
		ex_next_pc  = 32'h0000_1800;
		tick();
		ex_redirect = 1'b0;
		repeat (3) tick();
		stall = 1'b0;
		repeat (2) tick();

		// Training while stalled is seen once the stall drops
		ex_redirect = 1'b1;
		ex_next_pc  = BR_S;
		tick();
		ex_redirect = 1'b0;
		tick();
		stall     = 1'b1;
		if_branch = 1'b1;
		tick();
		repeat (3) resolve(BR_S, 1'b1, BR_U); // 10 to 11 and then saturated
		stall = 1'b0;
		tick();
		resolve(BR_U, 1'b1, BR_W); // Same-cycle bypass into the lookup
		if_branch = 1'b0;
		repeat (2) tick();

		for (int i = 0; i < 64; i++) begin
			random_bits(3, r_row);
			random_bits(1, r_taken);
			random_bits(3, r_dest);
			random_bits(1, r_branch);
			ex_resolve  = 1'b1;
			ex_pc       = {RAND_BASE[31:5], r_row[2:0], 2'b00};
			ex_taken    = r_taken[0];
			ex_target   = {RAND_BASE[31:5], r_dest[2:0], 2'b00};
			if_branch   = r_branch[0];
			ex_redirect = (i % 16 == 0); // Pull fetch back into the trained rows
			ex_next_pc  = {RAND_BASE[31:5], r_dest[2:0], 2'b00};
			tick();
		end
		ex_resolve  = 1'b0;
		ex_redirect = 1'b0;
		if_branch   = 1'b0;
		repeat (3) tick();

		$display("result: %0d model errors, %0d protocol errors", errors,
			DUT.u_props.fail_count);
		if (errors == 0 && DUT.u_props.fail_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
hw/bp_pkg.sv
hw/btb.sv
hw/direction_counters.sv
hw/fetch_fsm.sv
hw/branch_predictor_top.sv
tests/branch_predictor_props.sv
tests/branch_predictor_tb.sv
